//--- files.f
vlane_params_pkg.sv
vlane_types_pkg.sv
vector_lane_if.sv
arithmetic_unit.sv
multiply_unit.sv
divide_unit.sv
vector_lane.sv
vector_lane_top.sv
tb_vector_lane.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the vector lane testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_vector_lane -f files.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_vector_lane > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed" "$LOG"; then
  exit 0
fi
exit 1

//--- tb_vector_lane.sv
/*
 * Vector lane testbench
 * LCG-driven ops into all three units, reference queue in issue order,
 * concurrent assertions check results, timing and back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

module tb_vector_lane
  import vlane_params_pkg::*, vlane_types_pkg::*;
();

  localparam int CLK_PERIOD      = 100;
  localparam int RESET_CYCLES    = 16;
  localparam int NUM_OPS         = 400;
  localparam int WATCHDOG_CYCLES = NUM_OPS * (DIV_ITERS + 8) + RESET_CYCLES;
  localparam logic [ELEN-1:0] MOST_NEG = {1'b1, {(ELEN-1){1'b0}}};

  logic            CLK;
  logic            rst;
  logic            in_valid, in_ready;
  fu_type_t        in_fu;
  op_code_t        in_op;
  logic [ELEN-1:0] in_a, in_b;
  logic            out_valid, out_ready;
  logic [ELEN-1:0] out_result;
  logic            busy;

  // Model state, updated at the falling edge when all signals are settled
  logic [ELEN-1:0] model_q[$];
  logic [ELEN-1:0] exp_head;               // Head before the coming edge
  logic [ELEN-1:0] taken_res;              // Model value of the op at the coming edge
  fu_type_t        taken_fu, seen_fu;      // seen_fu is the last accepted unit
  logic            took_in, took_out;      // Transfers at the coming edge
  logic [ELEN-1:0] res_cycle, res_prev;    // out_result at the last two falling edges
  int              q_count, n_in, n_out;
  logic [31:0]     seed;

  vector_lane_top vector_lane_top_inst (
    .CLK        (CLK),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_fu      (in_fu),
    .in_op      (in_op),
    .in_a       (in_a),
    .in_b       (in_b),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result),
    .busy       (busy)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic value_error(input string sig, input logic [31:0] exp, input logic [31:0] act);
    abort_run($sformatf("Fail at %0t: %s expected %h, got %h", $time, sig, exp, act));
  endtask

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Upper LCG bits only, the low ones cycle fast
  function automatic int pick_below(input int n);
    logic [31:0] r;
    r = lcg_next();
    return int'(r[31:16]) % n;
  endfunction

  function automatic logic [ELEN-1:0] fresh_word();
    logic [31:0] hi, lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi[31:16], lo[31:16]};
  endfunction

  function automatic logic [ELEN-1:0] corner_value(input int k);
    case (k)
      0:       return '0;
      1:       return '1;
      default: return MOST_NEG;
    endcase
  endfunction

  // Reference results straight from the RISC-V op definitions
  function automatic logic [ELEN-1:0] expected_result(input fu_type_t fu, input op_code_t op,
                                                      input logic [ELEN-1:0] a,
                                                      input logic [ELEN-1:0] b);
    logic [2*ELEN-1:0] p;
    logic [ELEN-1:0]   r;
    logic              is_signed, is_rem;
    r = '0;
    case (fu)
      ARITH: begin
        case (arith_op_t'(op))
          VADD:    r = a + b;
          VSUB:    r = a - b;
          VAND:    r = a & b;
          VOR:     r = a | b;
          VXOR:    r = a ^ b;
          VSLL:    r = a << b[4:0];
          VSRL:    r = a >> b[4:0];
          VSRA:    r = $signed(a) >>> b[4:0];
          VMIN:    r = ($signed(a) < $signed(b)) ? a : b;
          VMINU:   r = (a < b) ? a : b;
          VMAX:    r = ($signed(a) < $signed(b)) ? b : a;
          VMAXU:   r = (a < b) ? b : a;
          default: r = '0;
        endcase
      end
      MUL: begin
        case (mul_op_t'(op[1:0]))
          VMULH:   p = $signed({{ELEN{a[ELEN-1]}}, a}) * $signed({{ELEN{b[ELEN-1]}}, b});
          VMULHU:  p = {{ELEN{1'b0}}, a} * {{ELEN{1'b0}}, b};
          default: p = a * b;
        endcase
        r = (mul_op_t'(op[1:0]) == VMUL) ? p[ELEN-1:0] : p[2*ELEN-1:ELEN];
      end
      default: begin
        is_signed = (div_op_t'(op[1:0]) == VDIV) || (div_op_t'(op[1:0]) == VREM);
        is_rem    = (div_op_t'(op[1:0]) == VREM) || (div_op_t'(op[1:0]) == VREMU);
        if (b == '0) begin
          r = is_rem ? a : '1;  // Divide by zero
        end else if (is_signed && a == MOST_NEG && b == '1) begin
          r = is_rem ? '0 : a;  // Signed overflow
        end else if (is_signed && is_rem) begin
          r = $signed(a) % $signed(b);
        end else if (is_signed) begin
          r = $signed(a) / $signed(b);
        end else begin
          r = is_rem ? a % b : a / b;
        end
      end
    endcase
    return r;
  endfunction

  task automatic new_operation(input int idx);
    fu_type_t fu;
    fu = fu_type_t'(pick_below(3));
    in_fu = fu;
    case (fu)
      ARITH:   in_op = op_code_t'(pick_below(12));
      MUL:     in_op = op_code_t'(pick_below(3));
      default: in_op = op_code_t'(pick_below(4));
    endcase
    in_a = fresh_word();
    in_b = fresh_word();
    if (idx % 7 == 3) in_a = corner_value((idx / 7) % 3);   // Zero, minus one, most negative
    if (idx % 5 == 2) in_b = corner_value((idx / 5) % 3);
    if (idx % 11 == 5) begin
      in_a = MOST_NEG;  // Overflow pair
      in_b = '1;
    end
    in_valid = 1'b1;
  endtask

  // Commit the transfers of the edge just passed, then look at the coming one
  always @(negedge CLK) begin
    if (rst) begin
      took_in  = 1'b0;
      took_out = 1'b0;
    end else begin
      if (took_out) begin
        model_q.delete(0);
        n_out++;
      end
      if (took_in) begin
        model_q.push_back(taken_res);
        seen_fu = taken_fu;
        n_in++;
      end
      took_in   = in_valid && in_ready;
      took_out  = out_valid && out_ready;
      taken_res = expected_result(in_fu, in_op, in_a, in_b);
      taken_fu  = in_fu;
    end
    exp_head = '0;
    if (model_q.size() != 0) exp_head = model_q[0];
    q_count   = model_q.size();
    res_prev  = res_cycle;
    res_cycle = out_result;
  end

  a_result: assert property (@(posedge CLK) disable iff (rst)
    out_valid && out_ready |-> out_result == exp_head)
    else value_error("out_result", $sampled(exp_head), $sampled(out_result));

  a_no_orphan: assert property (@(posedge CLK) disable iff (rst)
    out_valid |-> q_count != 0)
    else abort_run("out_valid is high with no operation outstanding");

  // Busy follows the model's outstanding count
  a_busy: assert property (@(posedge CLK) disable iff (rst)
    busy == (q_count != 0))
    else value_error("busy", $sampled(q_count) != 0, $sampled(busy));

  a_arith_lat: assert property (@(posedge CLK) disable iff (rst)
    in_valid && in_ready && in_fu == ARITH |=> out_valid)
    else value_error("out_valid", 1, 0);

  // Two cycles when the second edge is not stalled
  a_mul_lat: assert property (@(posedge CLK) disable iff (rst)
    $past(in_valid && in_ready && in_fu == MUL) && out_ready |=> out_valid)
    else value_error("out_valid", 1, 0);

  a_mul_stream: assert property (@(posedge CLK) disable iff (rst)
    $past(in_valid && in_ready && in_fu == MUL) && in_valid && in_fu == MUL && out_ready
    |-> in_ready)
    else value_error("in_ready", 1, 0);

  a_hold_valid: assert property (@(posedge CLK) disable iff (rst)
    out_valid && !out_ready |=> out_valid)
    else value_error("out_valid", 1, 0);

  a_hold_result: assert property (@(posedge CLK) disable iff (rst)
    out_valid && !out_ready |=> out_result == res_prev)
    else value_error("out_result", $sampled(res_prev), $sampled(out_result));

  a_unit_order: assert property (@(posedge CLK) disable iff (rst)
    q_count != 0 && in_fu != seen_fu |-> !in_ready)
    else value_error("in_ready", 0, 1);

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    abort_run("Timeout: the lane stopped accepting operations or returning results");
  end

  initial begin
    int issued;
    CLK       = 1'b0;
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_fu     = ARITH;
    in_op     = '0;
    in_a      = '0;
    in_b      = '0;
    out_ready = 1'b0;
    seed      = 32'd86;
    seen_fu   = ARITH;
    n_in      = 0;
    n_out     = 0;
    issued    = 0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1 rst = 1'b0;

    // Idle lane straight out of reset
    assert (!out_valid) else value_error("out_valid", 0, out_valid);
    assert (!busy) else value_error("busy", 0, busy);
    assert (in_ready) else value_error("in_ready", 1, in_ready);

    while (issued < NUM_OPS) begin
      @(posedge CLK);
      #1;
      if (took_in) begin
        issued++;
        in_valid = 1'b0;
      end
      out_ready = (pick_below(4) != 0);  // Back-pressure one cycle in four
      if (!in_valid && issued < NUM_OPS && pick_below(8) != 0) begin
        new_operation(issued);
      end
    end

    // Drain the lane
    while (n_out < NUM_OPS) begin
      @(posedge CLK);
      #1;
      out_ready = (pick_below(4) != 0);
    end
    repeat (2) @(posedge CLK);
    #1;

    if (model_q.size() != 0) begin
      value_error("model queue size", 0, model_q.size());
    end else if (busy) begin
      value_error("busy", 0, busy);
    end else if (n_out != n_in) begin
      value_error("result count", n_in, n_out);
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- vector_lane_top.sv
/*
 * Vector lane top level
 * Dispatch lane plus arithmetic, multiply and divide units on one interface
 */
`timescale 1ns/1ps
`default_nettype none

module vector_lane_top
  import vlane_params_pkg::*, vlane_types_pkg::*;
(
  input  logic            CLK,
  input  logic            rst,
  input  logic            in_valid,
  output logic            in_ready,
  input  fu_type_t        in_fu,
  input  op_code_t        in_op,
  input  logic [ELEN-1:0] in_a,
  input  logic [ELEN-1:0] in_b,
  output logic            out_valid,
  input  logic            out_ready,
  output logic [ELEN-1:0] out_result,
  output logic            busy
);

  vector_lane_if vif ();

  vector_lane lane (
    .CLK        (CLK),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_fu      (in_fu),
    .in_op      (in_op),
    .in_a       (in_a),
    .in_b       (in_b),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result),
    .busy       (busy),
    .vif        (vif)
  );

  // Units hang off the shared interface
  arithmetic_unit au (
    .CLK (CLK),
    .rst (rst),
    .aif (vif)
  );

  multiply_unit mulu (
    .CLK (CLK),
    .rst (rst),
    .mif (vif)
  );

  divide_unit divu (
    .CLK (CLK),
    .rst (rst),
    .dif (vif)
  );

endmodule

`default_nettype wire

//--- vector_lane.sv
/*
 * Vector lane dispatch
 * Routes each op to its unit, holds unit changes until the lane drains,
 * muxes the in-order result stream back out
 */
`timescale 1ns/1ps
`default_nettype none

module vector_lane
  import vlane_params_pkg::*, vlane_types_pkg::*;
(
  input  logic            CLK,
  input  logic            rst,
  input  logic            in_valid,
  output logic            in_ready,
  input  fu_type_t        in_fu,
  input  op_code_t        in_op,
  input  logic [ELEN-1:0] in_a,
  input  logic [ELEN-1:0] in_b,
  output logic            out_valid,
  input  logic            out_ready,
  output logic [ELEN-1:0] out_result,
  output logic            busy,
  vector_lane_if.lane     vif
);

  fu_type_t                        last_fu;  // Unit of the last issued op
  logic [$clog2(MUL_STAGES+1)-1:0] cnt;      // Results still inside the units
  logic                            tgt_ready;
  logic                            in_fire, out_fire;

  always_comb begin
    case (in_fu)
      ARITH:   tgt_ready = vif.ready_a;
      MUL:     tgt_ready = vif.ready_mu;
      DIV:     tgt_ready = vif.ready_du;
      default: tgt_ready = 1'b0;  // Unknown unit never issues
    endcase
  end

  // Same unit may stream, a new unit waits for an empty lane
  assign in_ready = tgt_ready && ((cnt == '0) || (in_fu == last_fu));
  assign in_fire  = in_valid && in_ready;

  assign vif.start_a   = in_fire && (in_fu == ARITH);
  assign vif.start_mu  = in_fire && (in_fu == MUL);
  assign vif.start_div = in_fire && (in_fu == DIV);
  assign vif.op        = in_op;
  assign vif.opa       = in_a;
  assign vif.opb       = in_b;

  // Oldest outstanding op always belongs to last_fu
  always_comb begin
    case (last_fu)
      ARITH: begin
        out_valid  = vif.valid_a;
        out_result = vif.wdata_a;
      end
      MUL: begin
        out_valid  = vif.valid_mu;
        out_result = vif.wdata_mu;
      end
      DIV: begin
        out_valid  = vif.valid_du;
        out_result = vif.wdata_du;
      end
      default: begin
        out_valid  = 1'b0;
        out_result = '0;
      end
    endcase
  end

  assign vif.accept_a  = out_ready && (last_fu == ARITH);
  assign vif.accept_mu = out_ready && (last_fu == MUL);
  assign vif.accept_du = out_ready && (last_fu == DIV);
  assign out_fire      = out_valid && out_ready;

  always_ff @(posedge CLK) begin
    if (rst) begin
      last_fu <= ARITH;
      cnt     <= '0;
    end else begin
      if (in_fire) begin
        last_fu <= in_fu;
      end
      case ({in_fire, out_fire})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: ;  // In and out together, no change
      endcase
    end
  end

  assign busy = (cnt != '0);

  a_one_start: assert property (@(posedge CLK) disable iff (rst)
    $onehot0({vif.start_a, vif.start_mu, vif.start_div}))
    else $error("vector_lane: more than one start pulse");

  // A result can only leave if it was issued
  a_no_underflow: assert property (@(posedge CLK) disable iff (rst)
    out_fire |-> (cnt != '0))
    else $error("vector_lane: outstanding count underflow");

  a_out_hold: assert property (@(posedge CLK) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_result))
    else $error("vector_lane: out_valid or out_result dropped under back-pressure");

endmodule

`default_nettype wire

//--- divide_unit.sv
/*
 * Divide unit
 * Radix-2 restoring divider on magnitudes with sign fix-up,
 * RISC-V divide-by-zero and overflow results bypass the loop
 */
`timescale 1ns/1ps
`default_nettype none

module divide_unit
  import vlane_params_pkg::*, vlane_types_pkg::*;
(
  input logic CLK,
  input logic rst,
  vector_lane_if.div dif
);

  div_state_t                     state;
  logic [$clog2(DIV_ITERS+1)-1:0] cnt;
  div_op_t                        dop;
  logic                           op_signed, op_rem;
  logic                           sa, sb;
  logic                           div_zero, div_ovf;
  logic [ELEN-1:0]                quo, rem, dvs, res;
  logic                           neg_q, neg_r, rem_sel;
  logic [ELEN:0]                  shifted, diff;

  assign dop       = div_op_t'(dif.op[1:0]);
  assign op_signed = (dop == VDIV) || (dop == VREM);
  assign op_rem    = (dop == VREM) || (dop == VREMU);
  assign sa        = op_signed & dif.opa[ELEN-1];
  assign sb        = op_signed & dif.opb[ELEN-1];
  assign div_zero  = (dif.opb == '0);
  assign div_ovf   = op_signed && (dif.opa == {1'b1, {(ELEN-1){1'b0}}}) && (dif.opb == '1);

  // One restoring step
  assign shifted = {rem, quo[ELEN-1]};
  assign diff    = shifted - {1'b0, dvs};

  always_ff @(posedge CLK) begin
    if (rst) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        IDLE: if (dif.start_div) begin
          cnt   <= '0;
          state <= (div_zero || div_ovf) ? DONE : CALC;  // Special cases skip the loop
        end
        CALC: begin
          cnt <= cnt + 1'b1;
          if (cnt == $bits(cnt)'(DIV_ITERS - 1)) begin
            state <= FIX;
          end
        end
        FIX:  state <= DONE;
        DONE: if (dif.accept_du) begin
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge CLK) begin
    case (state)
      IDLE: if (dif.start_div) begin
        if (div_zero) begin
          res <= op_rem ? dif.opa : '1;  // q = all ones, r = dividend
        end else if (div_ovf) begin
          res <= op_rem ? '0 : dif.opa;  // q = dividend, r = 0
        end
        quo     <= sa ? -dif.opa : dif.opa;  // Magnitudes
        dvs     <= sb ? -dif.opb : dif.opb;
        rem     <= '0;
        neg_q   <= sa ^ sb;
        neg_r   <= sa;  // Remainder follows dividend
        rem_sel <= op_rem;
      end
      CALC: begin
        if (!diff[ELEN]) begin
          rem <= diff[ELEN-1:0];
          quo <= {quo[ELEN-2:0], 1'b1};
        end else begin
          rem <= shifted[ELEN-1:0];  // Restore
          quo <= {quo[ELEN-2:0], 1'b0};
        end
      end
      FIX: begin
        if (rem_sel) begin
          res <= neg_r ? -rem : rem;
        end else begin
          res <= neg_q ? -quo : quo;
        end
      end
      default: ;
    endcase
  end

  assign dif.ready_du = (state == IDLE);
  assign dif.valid_du = (state == DONE);
  assign dif.wdata_du = res;

  a_cnt_range: assert property (@(posedge CLK) disable iff (rst)
    (state == CALC) |-> (cnt < $bits(cnt)'(DIV_ITERS)))
    else $error("divide_unit: iteration counter out of range");

  a_start_idle: assert property (@(posedge CLK) disable iff (rst)
    dif.start_div |-> (state == IDLE))
    else $error("divide_unit: start_div outside IDLE");

endmodule

`default_nettype wire

//--- multiply_unit.sv
/*
 * Multiply unit
 * Two-stage 32x32 multiplier, operand stage then product stage,
 * both stall while the last stage waits on the lane
 */
`timescale 1ns/1ps
`default_nettype none

module multiply_unit
  import vlane_params_pkg::*, vlane_types_pkg::*;
(
  input logic CLK,
  input logic rst,
  vector_lane_if.mul mif
);

  mul_op_t                  mop;
  logic                     ext_signed;
  logic [MUL_STAGES-1:0]    vld;  // Bit 0 operand stage, top bit product stage
  logic                     adv;
  logic signed [ELEN:0]     s1_a, s1_b;  // One extra bit for sign or zero extension
  mul_op_t                  s1_op;
  logic signed [2*ELEN+1:0] prod;
  logic [ELEN-1:0]          s2_res;

  assign mop        = mul_op_t'(mif.op[1:0]);
  assign ext_signed = (mop != VMULHU);  // VMUL low word is sign-agnostic

  // Whole pipe moves when last stage is free or leaving
  assign adv = !vld[MUL_STAGES-1] || mif.accept_mu;

  always_ff @(posedge CLK) begin
    if (rst) begin
      vld <= '0;
    end else if (adv) begin
      vld <= {vld[MUL_STAGES-2:0], mif.start_mu};
    end
  end

  // Stage one, extended operands
  always_ff @(posedge CLK) begin
    if (mif.start_mu) begin
      s1_a  <= {ext_signed & mif.opa[ELEN-1], mif.opa};
      s1_b  <= {ext_signed & mif.opb[ELEN-1], mif.opb};
      s1_op <= mop;
    end
  end

  assign prod = s1_a * s1_b;

  // Stage two, word select
  always_ff @(posedge CLK) begin
    if (adv && vld[0]) begin
      if (s1_op == VMUL) begin
        s2_res <= prod[ELEN-1:0];
      end else begin
        s2_res <= prod[2*ELEN-1:ELEN];  // High word, signed or unsigned
      end
    end
  end

  assign mif.ready_mu = adv;
  assign mif.valid_mu = vld[MUL_STAGES-1];
  assign mif.wdata_mu = s2_res;

  // Result held under back-pressure
  a_hold_on_stall: assert property (@(posedge CLK) disable iff (rst)
    mif.valid_mu && !mif.accept_mu |=> mif.valid_mu && $stable(mif.wdata_mu))
    else $error("multiply_unit: result changed while stalled");

endmodule

`default_nettype wire

//--- arithmetic_unit.sv
/*
 * Arithmetic unit
 * Add, sub, logic, shifts and min/max in one cycle,
 * result parked in an output register until the lane takes it
 */
`timescale 1ns/1ps
`default_nettype none

module arithmetic_unit
  import vlane_params_pkg::*, vlane_types_pkg::*;
(
  input logic CLK,
  input logic rst,
  vector_lane_if.arith aif
);

  arith_op_t               aop;
  logic [$clog2(ELEN)-1:0] shamt;
  logic [ELEN-1:0]         alu_res;
  logic [ELEN-1:0]         res_q;
  logic                    vld_q;
  logic                    lt_s, lt_u;

  assign aop   = arith_op_t'(aif.op);
  assign shamt = aif.opb[$clog2(ELEN)-1:0];  // Low five bits only

  // Compares shared by min and max
  assign lt_s = $signed(aif.opa) < $signed(aif.opb);
  assign lt_u = aif.opa < aif.opb;

  always_comb begin
    case (aop)
      VADD:    alu_res = aif.opa + aif.opb;
      VSUB:    alu_res = aif.opa - aif.opb;
      VAND:    alu_res = aif.opa & aif.opb;
      VOR:     alu_res = aif.opa | aif.opb;
      VXOR:    alu_res = aif.opa ^ aif.opb;
      VSLL:    alu_res = aif.opa << shamt;
      VSRL:    alu_res = aif.opa >> shamt;
      VSRA:    alu_res = $signed(aif.opa) >>> shamt;  // Sign fill
      VMIN:    alu_res = lt_s ? aif.opa : aif.opb;
      VMINU:   alu_res = lt_u ? aif.opa : aif.opb;
      VMAX:    alu_res = lt_s ? aif.opb : aif.opa;
      VMAXU:   alu_res = lt_u ? aif.opb : aif.opa;
      default: alu_res = '0;  // Unused encodings
    endcase
  end

  // Output register valid bit
  always_ff @(posedge CLK) begin
    if (rst) begin
      vld_q <= 1'b0;
    end else if (aif.start_a) begin
      vld_q <= 1'b1;  // New op replaces any result leaving now
    end else if (aif.accept_a) begin
      vld_q <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (aif.start_a) begin
      res_q <= alu_res;
    end
  end

  assign aif.ready_a = !vld_q || aif.accept_a;  // Empty or draining this cycle
  assign aif.valid_a = vld_q;
  assign aif.wdata_a = res_q;

  // Lane must respect back-pressure
  a_start_when_ready: assert property (@(posedge CLK) disable iff (rst)
    aif.start_a |-> aif.ready_a)
    else $error("arithmetic_unit: start_a while not ready");

endmodule

`default_nettype wire

//--- vector_lane_if.sv
/*
 * Lane to functional-unit interface
 * Start pulses and operands out, ready/valid/result back per unit
 */
`timescale 1ns/1ps
`default_nettype none

interface vector_lane_if
  import vlane_params_pkg::*, vlane_types_pkg::*;
();

  // Issue side, shared operand bus
  logic            start_a, start_mu, start_div;
  op_code_t        op;
  logic [ELEN-1:0] opa, opb;

  // Result side, one set per unit
  logic            ready_a, ready_mu, ready_du;
  logic            valid_a, valid_mu, valid_du;
  logic [ELEN-1:0] wdata_a, wdata_mu, wdata_du;
  logic            accept_a, accept_mu, accept_du;  // out_ready steered to active unit

  modport lane (
    output start_a, start_mu, start_div, op, opa, opb,
    output accept_a, accept_mu, accept_du,
    input  ready_a, ready_mu, ready_du,
    input  valid_a, valid_mu, valid_du,
    input  wdata_a, wdata_mu, wdata_du
  );

  modport arith (
    input  start_a, op, opa, opb, accept_a,
    output ready_a, valid_a, wdata_a
  );

  modport mul (
    input  start_mu, op, opa, opb, accept_mu,
    output ready_mu, valid_mu, wdata_mu
  );

  modport div (
    input  start_div, op, opa, opb, accept_du,
    output ready_du, valid_du, wdata_du
  );

endinterface

`default_nettype wire

//--- vlane_types_pkg.sv
/*
 * Vector lane types
 * Functional-unit select, per-unit opcodes and divider FSM states
 */
`default_nettype none

package vlane_types_pkg;

  typedef enum logic [1:0] {
    ARITH,
    MUL,
    DIV
  } fu_type_t;

  // Raw opcode field, meaning depends on fu_type_t
  typedef logic [3:0] op_code_t;

  typedef enum logic [3:0] {
    VADD, VSUB,
    VAND, VOR, VXOR,
    VSLL, VSRL, VSRA,
    VMIN, VMINU, VMAX, VMAXU
  } arith_op_t;

  typedef enum logic [1:0] {
    VMUL,   // Low word
    VMULH,  // Signed x signed, high word
    VMULHU  // Unsigned x unsigned, high word
  } mul_op_t;

  typedef enum logic [1:0] {
    VDIV, VDIVU,
    VREM, VREMU
  } div_op_t;

  typedef enum logic [1:0] {
    IDLE,  // Waiting for start
    CALC,  // Restoring steps
    FIX,   // Sign correction
    DONE   // Result held until accepted
  } div_state_t;

endpackage

`default_nettype wire

//--- vlane_params_pkg.sv
/*
 * Vector lane parameters
 * Element width and the depth of the multi-cycle units
 */
`default_nettype none

package vlane_params_pkg;

  // One RV32 element per lane
  localparam int ELEN = 32;

  // Operand stage plus product stage
  localparam int MUL_STAGES = 2;

  // One quotient bit per restoring step
  localparam int DIV_ITERS = ELEN;

endpackage

`default_nettype wire
